// ==== flist.f ====
+incdir+.
cpuPkg.sv
cpuIfs.sv
regFile.sv
execUnit.sv
instrSequencer.sv
cpuTop.sv
tbCpu.sv

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it, then scan the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  -f flist.f --top-module tbCpu -o simCpu

./obj_dir/simCpu > sim.log 2>&1
cat sim.log

if grep -q "Something failed" sim.log; then
  echo "simulation reported a failure"
  exit 1
fi

echo "simulation passed"
exit 0

// ==== tbCpu.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "cpu_macros.svh"

module tbCpu import cpuPkg::*; ();

  localparam int    MemWords    = 2048;     // 8 KB holding program, data and stack
  localparam int    ClkPeriod   = 40;
  localparam int    ResetCycles = 5;
  localparam addr_t DataBase    = 32'h1000;
  localparam int    NumTests    = 6;

  logic  clk;
  logic  rstN;
  word_t ramIn;
  addr_t ramAddress;
  word_t ramOut;
  logic  readReq;
  logic  writeReq;
  word_t debugOut;
  logic  debugValid;

  word_t mem [MemWords];
  word_t mdl [`CPU_NUM_REGS];  // Register values the program should leave
  word_t expVal [$];           // Debug outputs in program order
  int    expTest [$];
  addr_t stAddr [$];           // Expected writes in order
  word_t stData [$];
  int    stTest [$];
  string testName [NumTests] = '{"bus", "arith", "loadstore", "branch", "stack", "stall"};
  int    checks [NumTests];
  int    fails [NumTests];
  int    pending [NumTests];   // Debug outputs still to come per test
  bit    reported [NumTests];
  addr_t pc;                   // Build pointer
  int    instrCount;
  int    curTest;
  addr_t stallAddr;
  addr_t lastRead;
  bit    seenFetch;
  bit    afterDebug;
  bit    rdPending;            // Read sampled on the previous falling edge
  word_t rdWord;

  cpuTop i_dut (
    .clk        (clk),
    .rstN       (rstN),
    .ramIn      (ramIn),
    .ramAddress (ramAddress),
    .ramOut     (ramOut),
    .readReq    (readReq),
    .writeReq   (writeReq),
    .debugOut   (debugOut),
    .debugValid (debugValid)
  );

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  // Register byte with an upper nibble of noise for the core to ignore
  function automatic logic [7:0] regByte(input int r);
    return {4'($urandom()), 4'(r)};
  endfunction

  function automatic word_t flagsOf(input word_t x, input word_t y);
    return {29'd0, x > y, x < y, x == y};  // gt, lt, eq
  endfunction

  function automatic word_t arithRef(input opCode_t op, input word_t a, input word_t b,
                                     input word_t c, input word_t k);
    case (op)
      AddRRR:  return b + c;
      AddRRC:  return b + k;
      SubRRR:  return b - c;
      SubRRC:  return b - k;
      IncR:    return a + 32'd1;
      DecR:    return a - 32'd1;
      ShlRRR:  return b << c;
      ShrRRR:  return b >> c;
      NegRR:   return 32'd0 - b;
      default: return b;  // MovRR
    endcase
  endfunction

  task automatic putWord(input addr_t a, input word_t w);
    mem[a[12:2]] = w;
  endtask

  task automatic emitShort(input opCode_t op, input int a, input int b, input int c);
    putWord(pc, {regByte(c), regByte(b), regByte(a), op});
    pc += `CPU_INSTR_BYTES;
    instrCount++;
  endtask

  task automatic emitLong(input opCode_t op, input int a, input int b, input int c,
                          input word_t d);
    emitShort(op, a, b, c);
    putWord(pc, d);  // Trailing data word
    pc += `CPU_LONG_INSTR_BYTES - `CPU_INSTR_BYTES;
  endtask

  task automatic movConst(input int r, input word_t v);
    emitLong(MovRC, r, 0, 0, v);
    mdl[r] = v;
  endtask

  task automatic emitDebug(input int r);
    emitShort(DoutR, r, 0, 0);
    expVal.push_back(mdl[r]);
    expTest.push_back(curTest);
    pending[curTest]++;
  endtask

  task automatic expectStore(input addr_t a, input word_t d);
    stAddr.push_back(a);
    stData.push_back(d);
    stTest.push_back(curTest);
  endtask

  task automatic runArith(input opCode_t op, input int d, input int b, input int c,
                          input word_t k);
    if (op inside {AddRRC, SubRRC}) begin
      emitLong(op, d, b, c, k);
    end else begin
      emitShort(op, d, b, c);
    end
    mdl[d] = arithRef(op, mdl[d], mdl[b], mdl[c], k);
    emitDebug(d);
  endtask

  // Jump, then fall-through marker, skip and taken marker
  task automatic emitBranch(input opCode_t op, input int c, input bit taken);
    addr_t at;
    at = pc;
    emitLong(op, 0, 0, c, at + 2 * `CPU_LONG_INSTR_BYTES + `CPU_INSTR_BYTES);
    emitShort(DoutR, 15, 0, 0);
    emitLong(JmpC, 0, 0, 0, at + 2 * `CPU_LONG_INSTR_BYTES + 2 * `CPU_INSTR_BYTES);
    emitShort(DoutR, 14, 0, 0);
    expVal.push_back(taken ? mdl[14] : mdl[15]);
    expTest.push_back(curTest);
    pending[curTest]++;
  endtask

  task automatic buildProgram();
    word_t x;
    word_t y;
    word_t k;
    addr_t a;
    addr_t base;
    addr_t off;
    addr_t sp;
    curTest = 1;  // Arithmetic on random constants
    movConst(2, $urandom());
    movConst(3, $urandom());
    k = $urandom();
    runArith(AddRRR, 4, 2, 3, k);
    runArith(AddRRC, 5, 2, 0, k);
    runArith(SubRRR, 6, 2, 3, k);
    runArith(SubRRC, 7, 3, 0, k);
    runArith(IncR, 4, 0, 0, k);
    runArith(DecR, 5, 0, 0, k);
    movConst(8, $urandom() % 32);  // Shift amount
    runArith(ShlRRR, 9, 2, 8, k);
    runArith(ShrRRR, 10, 3, 8, k);
    runArith(NegRR, 11, 2, 0, k);
    runArith(MovRR, 12, 3, 0, k);
    movConst(13, 32'hFFFF_FFFF);   // Wraps to zero
    runArith(IncR, 13, 0, 0, k);
    curTest = 2;  // Direct and offset stores read back two ways
    a = DataBase + 4 * ($urandom() % 512);
    movConst(4, $urandom());
    emitLong(MovdCR, 0, 4, 0, a);
    expectStore(a, mdl[4]);
    emitLong(MovRdC, 5, 0, 0, a);
    mdl[5] = mdl[4];
    emitDebug(5);
    base = DataBase + 4 * ($urandom() % 256);
    off  = 4 * ($urandom() % 256);
    movConst(6, base);
    movConst(7, $urandom());
    emitLong(MovdRoR, 6, 7, 0, off);
    expectStore(base + off, mdl[7]);
    movConst(8, base + off);
    emitShort(MovRdR, 9, 8, 0);
    mdl[9] = mdl[7];
    emitDebug(9);
    curTest = 3;
    movConst(14, 32'h7A4E_0001);  // Taken
    movConst(15, 32'h0F0F_0002);  // Not taken
    for (int r = 0; r < 4; r++) begin
      x = $urandom();
      y = (r % 2 == 0) ? x : $urandom();  // Even rounds compare equal
      movConst(2, x);
      movConst(3, y);
      emitShort(CmpRR, 2, 3, 0);
      mdl[1] = flagsOf(x, y);
      emitDebug(1);
      emitBranch(JeC, 0, mdl[1][0]);
      emitBranch(JneC, 0, !mdl[1][0]);
      emitLong(CmpRC, 3, 0, 0, x);  // Operands swapped
      mdl[1] = flagsOf(y, x);
      emitDebug(1);
      emitBranch(JeC, 0, mdl[1][0]);
      emitShort(CmpERRR, 4, 2, 3);
      mdl[4] = word_t'(x == y);
      emitBranch(JzRC, 4, mdl[4] == '0);
      emitBranch(JnzRC, 4, mdl[4] != '0);
      emitShort(CmpLtRRR, 5, 2, 3);
      mdl[5] = word_t'(x < y);
      emitDebug(5);
      emitBranch(JnzRC, 5, mdl[5] != '0);
    end
    curTest = 4;  // Stack grows upward from sp
    sp = 32'h1C00 + 4 * ($urandom() % 64);
    movConst(0, sp);
    movConst(5, $urandom());
    movConst(6, $urandom());
    emitShort(PushR, 5, 0, 0);
    expectStore(sp, mdl[5]);
    emitShort(PushR, 6, 0, 0);
    expectStore(sp + `CPU_STACK_STEP, mdl[6]);
    emitShort(PopR, 7, 0, 0);
    mdl[7] = mdl[6];
    emitShort(PopR, 8, 0, 0);
    mdl[8] = mdl[5];
    emitDebug(7);
    emitDebug(8);
    emitDebug(0);  // Back to start
    curTest = 5;
    stallAddr = pc;
    emitShort(Stall, 0, 0, 0);
  endtask

  task automatic reportTest(input int t);
    if (!reported[t]) begin
      reported[t] = 1'b1;
      $display("test %s: %s, %0d checks, %0d errors", testName[t],
               (fails[t] == 0 && pending[t] == 0) ? "passed" : "FAILED", checks[t], fails[t]);
    end
  endtask

  // Read data shows up one clock after the falling-edge sample and holds until the next read
  always @(negedge clk) begin : memModel
    if (rdPending) begin
      ramIn <= rdWord;
    end
    rdPending = 1'b0;
    if (rstN && (readReq || writeReq)) begin
      checks[0]++;
      assert (ramAddress < MemWords * 4 && ramAddress[1:0] == 2'b00) else begin
        fails[0]++;
        $display("bus: request to address %h outside the memory or unaligned", ramAddress);
      end
      if (writeReq) begin
        mem[ramAddress[12:2]] = ramOut;
      end else begin
        rdWord    = mem[ramAddress[12:2]];
        rdPending = 1'b1;
      end
    end
  end

  always @(negedge clk) begin : busMonitor
    int    t;
    word_t v;
    addr_t a;
    if (!rstN) begin
      checks[0]++;
      assert (!readReq && !writeReq) else begin
        fails[0]++;
        $display("bus: memory request raised while in reset");
      end
    end else begin
      if (readReq) begin
        a = seenFetch ? lastRead + `CPU_INSTR_BYTES : '0;  // DoutR is short
        if (!seenFetch || afterDebug) begin
          checks[0]++;
          assert (ramAddress == a) else begin
            fails[0]++;
            $display("mismatch %s: fetch address expected %h, actual %h", testName[0], a,
                     ramAddress);
          end
        end
        seenFetch  = 1'b1;
        afterDebug = 1'b0;
        lastRead   = ramAddress;
      end
      if (writeReq) begin
        assert (stAddr.size() > 0) else begin
          fails[0]++;
          $display("bus: write to %h that the program never asked for", ramAddress);
        end
        if (stAddr.size() > 0) begin
          t = stTest.pop_front();
          a = stAddr.pop_front();
          v = stData.pop_front();
          checks[t] += 2;
          assert (ramAddress == a) else begin
            fails[t]++;
            $display("mismatch %s: write address expected %h, actual %h", testName[t], a,
                     ramAddress);
          end
          assert (ramOut == v) else begin
            fails[t]++;
            $display("mismatch %s: write data expected %h, actual %h", testName[t], v, ramOut);
          end
        end
      end
      if (debugValid) begin
        afterDebug = 1'b1;
        assert (expVal.size() > 0) else begin
          fails[5]++;
          $display("stall: debugValid pulsed after the last DoutR of the program");
        end
        if (expVal.size() > 0) begin
          t = expTest.pop_front();
          v = expVal.pop_front();
          checks[t]++;
          assert (debugOut == v) else begin
            fails[t]++;
            $display("mismatch %s: debugOut expected %h, actual %h", testName[t], v, debugOut);
          end
          pending[t]--;
          if (pending[t] == 0) begin
            reportTest(t);
          end
        end
      end
    end
  end

  // Memory requests and debugValid last a single cycle
  assert property (@(negedge clk) disable iff (!rstN)
                   (readReq || writeReq) |=> !(readReq || writeReq))
    else begin
      fails[0]++;
      $display("bus: memory request held for more than one cycle");
    end

  assert property (@(negedge clk) disable iff (!rstN) debugValid |=> !debugValid)
    else begin
      fails[0]++;
      $display("bus: debugValid held for more than one cycle");
    end

  initial begin : mainFlow
    longint limitNs;
    int     passed;
    int     errors;
    rstN  = 1'b0;
    ramIn = '0;
    void'($urandom(29371));
    pc = '0;
    instrCount = 0;
    seenFetch = 1'b0;
    afterDebug = 1'b0;
    lastRead = '0;
    rdPending = 1'b0;
    rdWord = '0;
    for (int i = 0; i < MemWords; i++) begin
      mem[i] = word_t'(i) * 32'h9E37_79B1;  // Filler that is never executed
    end
    for (int r = 0; r < `CPU_NUM_REGS; r++) begin
      mdl[r] = '0;
    end
    for (int t = 0; t < NumTests; t++) begin
      checks[t] = 0;
      fails[t] = 0;
      pending[t] = 0;
      reported[t] = 1'b0;
    end
    buildProgram();
    // Twice the worst case of 10 cycles per instruction
    limitNs = longint'(instrCount * 10 + ResetCycles) * ClkPeriod * 2;
    repeat (ResetCycles) @(negedge clk);
    rstN = 1'b1;
    #(limitNs + ClkPeriod / 4);
    if (expVal.size() > 0) begin
      fails[expTest[0]]++;
      $display("timeout: %0d debug outputs never appeared, first one from test %s",
               expVal.size(), testName[expTest[0]]);
    end
    if (stAddr.size() > 0) begin
      fails[stTest[0]]++;
      $display("timeout: %0d expected memory writes never appeared", stAddr.size());
    end
    checks[5]++;
    assert (lastRead == stallAddr) else begin
      fails[5]++;
      $display("stall: core stopped fetching at %h instead of spinning at %h", lastRead,
               stallAddr);
    end
    passed = 0;
    errors = 0;
    for (int t = 0; t < NumTests; t++) begin
      reportTest(t);
      errors += fails[t];
      if (fails[t] == 0 && pending[t] == 0) begin
        passed++;
      end
    end
    $display("%0d tests: %0d passed, %0d failed, %0d errors", NumTests, passed,
             NumTests - passed, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== cpuTop.sv ====
`default_nettype none
`timescale 1ns/100ps

module cpuTop import cpuPkg::*; (
  input wire    clk,
  input wire    rstN,
  input wire    word_t ramIn,  // Read data, one cycle after sampling
  output addr_t ramAddress,
  output word_t ramOut,
  output logic  readReq,
  output logic  writeReq,
  output word_t debugOut,
  output logic  debugValid     // Pulses on DoutR commit
);

  instrIf   insBus ();  // Sequencer to operation unit
  regPortIf regBus ();  // Sequencer to register file

  instrSequencer i_seq (
    .clk        (clk),
    .rstN       (rstN),
    .ramIn      (ramIn),
    .ramAddress (ramAddress),
    .ramOut     (ramOut),
    .readReq    (readReq),
    .writeReq   (writeReq),
    .debugOut   (debugOut),
    .debugValid (debugValid),
    .ins        (insBus.seq),
    .rf         (regBus.seq)
  );

  execUnit i_exec (
    .ins (insBus.exec)
  );

  regFile i_regs (
    .clk  (clk),
    .rstN (rstN),
    .rf   (regBus.rf)
  );

endmodule

`default_nettype wire

// ==== instrSequencer.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "cpu_macros.svh"

module instrSequencer import cpuPkg::*; (
  input wire    clk,
  input wire    rstN,
  input wire    word_t ramIn,
  output addr_t ramAddress,
  output word_t ramOut,
  output logic  readReq,
  output logic  writeReq,
  output word_t debugOut,
  output logic  debugValid,
  instrIf.seq   ins,
  regPortIf.seq rf
);

  seqState_t state;
  addr_t     ip;        // Instruction pointer
  word_t     loadData;  // Read result of loads and pops
  logic      commitNow;

  // Forms carrying a trailing data word
  function automatic logic isLongOp(input opCode_t op);
    return op inside {MovRC, MovRdC, MovdCR, MovdRoR, AddRRC, SubRRC, CmpRC,
                      JmpC, JeC, JneC, JzRC, JnzRC};
  endfunction

  // Forms with a data memory access
  function automatic logic isMemOp(input opCode_t op);
    return op inside {MovRdC, MovRdR, MovdCR, MovdRoR, PushR, PopR};
  endfunction

  function automatic logic isStoreOp(input opCode_t op);
    return op inside {MovdCR, MovdRoR, PushR};
  endfunction

  // Control path
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state      <= FetchIssue;
      ip         <= '0;
      readReq    <= 1'b0;
      writeReq   <= 1'b0;
      debugOut   <= '0;
      debugValid <= 1'b0;
    end else begin
      readReq    <= 1'b0;  // Requests are single-cycle pulses
      writeReq   <= 1'b0;
      debugValid <= 1'b0;
      case (state)
        FetchIssue: begin
          readReq <= 1'b1;
          state   <= FetchWait;
        end
        FetchWait: state <= Decode;
        Decode:    state <= RegRead;
        RegRead: begin
          if (isLongOp(ins.opCode)) begin
            readReq <= 1'b1;  // Fetch data word
            state   <= DataWait;
          end else if (isMemOp(ins.opCode)) begin
            state <= MemIssue;
          end else begin
            state <= Commit;
          end
        end
        DataWait: state <= DataDone;
        DataDone: state <= isMemOp(ins.opCode) ? MemIssue : Commit;
        MemIssue: begin
          if (isStoreOp(ins.opCode)) begin
            writeReq <= 1'b1;
          end else begin
            readReq <= 1'b1;
          end
          state <= MemWait;
        end
        MemWait: state <= MemDone;
        MemDone: state <= Commit;
        Commit: begin
          if (ins.opCode == DoutR) begin
            debugOut   <= ins.valA;
            debugValid <= 1'b1;
          end
          if (ins.branchTaken) begin
            ip <= ins.dataWord;
          end else if (ins.opCode != Stall) begin  // Stall spins on itself
            ip <= ip + (isLongOp(ins.opCode) ? `CPU_LONG_INSTR_BYTES : `CPU_INSTR_BYTES);
          end
          state <= FetchIssue;
        end
        default: state <= FetchIssue;
      endcase
    end
  end

  // Payload registers, loaded per state
  always_ff @(posedge clk) begin
    case (state)
      FetchIssue: ramAddress <= ip;
      Decode: begin
        ins.opCode <= opCode_t'(ramIn[7:0]);
        ins.regA   <= ramIn[8 +: `CPU_REG_IDX_W];   // Upper nibbles ignored
        ins.regB   <= ramIn[16 +: `CPU_REG_IDX_W];
        ins.regC   <= ramIn[24 +: `CPU_REG_IDX_W];
      end
      RegRead: begin
        // Flag jumps see flags in A, stack forms see sp in B
        ins.valA   <= (ins.opCode inside {JeC, JneC}) ? rf.flagValue : rf.rdData[0];
        ins.valB   <= (ins.opCode inside {PushR, PopR}) ? rf.spValue : rf.rdData[1];
        ins.valC   <= rf.rdData[2];
        ramAddress <= ip + `CPU_INSTR_BYTES;  // Data word follows opcode word
      end
      DataDone: ins.dataWord <= ramIn;
      MemIssue: begin
        ramAddress <= ins.memAddr;
        ramOut     <= ins.storeData;
      end
      MemDone: loadData <= ramIn;
      default: ;
    endcase
  end

  assign commitNow = (state == Commit);

  // Register file reads follow the latched fields
  assign rf.rdIdx = {ins.regC, ins.regB, ins.regA};

  // Writeback, flags go to their fixed register
  assign rf.resWe   = commitNow && (ins.resultWe || ins.flagsWe);
  assign rf.resIdx  = ins.flagsWe ? regIdx_t'(`CPU_FLAG_REG) : ins.regA;
  assign rf.resData = ins.flagsWe ? ins.flags :
                      isMemOp(ins.opCode) ? loadData : ins.result;
  assign rf.spWe    = commitNow && ins.spWe;
  assign rf.spData  = ins.spNext;

endmodule

`default_nettype wire

// ==== execUnit.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "cpu_macros.svh"

module execUnit import cpuPkg::*; (
  instrIf.exec ins
);

  word_t cmpRhs;  // Right-hand side of flag compares
  logic  cmpEq;
  logic  cmpLt;
  logic  cmpGt;

  // Flag compare, unsigned
  assign cmpRhs = (ins.opCode == CmpRC) ? ins.dataWord : ins.valB;
  assign cmpEq  = (ins.valA == cmpRhs);
  assign cmpLt  = (ins.valA < cmpRhs);
  assign cmpGt  = (ins.valA > cmpRhs);
  assign ins.flags = word_t'({cmpGt, cmpLt, cmpEq});  // bit0 eq, bit1 lt, bit2 gt

  // Result, memory and stack side
  always_comb begin
    ins.result    = '0;
    ins.resultWe  = 1'b0;
    ins.flagsWe   = 1'b0;
    ins.memAddr   = ins.dataWord;  // Direct address by default
    ins.storeData = ins.valB;
    ins.spNext    = ins.valB;
    ins.spWe      = 1'b0;
    case (ins.opCode)
      MovRC: begin
        ins.result   = ins.dataWord;
        ins.resultWe = 1'b1;
      end
      MovRR: begin
        ins.result   = ins.valB;
        ins.resultWe = 1'b1;
      end
      // Loads, data swapped in by the sequencer at commit
      MovRdC: ins.resultWe = 1'b1;
      MovRdR: begin
        ins.memAddr  = ins.valB;
        ins.resultWe = 1'b1;
      end
      MovdCR: ins.storeData = ins.valB;          // Store rB at const
      MovdRoR: ins.memAddr = ins.valA + ins.dataWord;  // rA plus offset
      PushR: begin
        ins.memAddr   = ins.valB;                // Write at current sp
        ins.storeData = ins.valA;
        ins.spNext    = ins.valB + `CPU_STACK_STEP;
        ins.spWe      = 1'b1;
      end
      PopR: begin
        ins.memAddr  = ins.valB - `CPU_STACK_STEP;  // Top of stack
        ins.spNext   = ins.valB - `CPU_STACK_STEP;
        ins.spWe     = 1'b1;
        ins.resultWe = 1'b1;
      end
      AddRRR: begin
        ins.result   = ins.valB + ins.valC;
        ins.resultWe = 1'b1;
      end
      AddRRC: begin
        ins.result   = ins.valB + ins.dataWord;
        ins.resultWe = 1'b1;
      end
      SubRRR: begin
        ins.result   = ins.valB - ins.valC;
        ins.resultWe = 1'b1;
      end
      SubRRC: begin
        ins.result   = ins.valB - ins.dataWord;
        ins.resultWe = 1'b1;
      end
      IncR: begin
        ins.result   = ins.valA + 1'b1;  // In place
        ins.resultWe = 1'b1;
      end
      DecR: begin
        ins.result   = ins.valA - 1'b1;
        ins.resultWe = 1'b1;
      end
      ShlRRR: begin
        ins.result   = ins.valB << ins.valC;  // Zero for shifts of 32 or more
        ins.resultWe = 1'b1;
      end
      ShrRRR: begin
        ins.result   = ins.valB >> ins.valC;  // Logical
        ins.resultWe = 1'b1;
      end
      NegRR: begin
        ins.result   = -ins.valB;
        ins.resultWe = 1'b1;
      end
      CmpRR, CmpRC: ins.flagsWe = 1'b1;  // Goes to the flag register
      CmpERRR: begin
        ins.result   = word_t'(ins.valB == ins.valC);
        ins.resultWe = 1'b1;
      end
      CmpLtRRR: begin
        ins.result   = word_t'(ins.valB < ins.valC);
        ins.resultWe = 1'b1;
      end
      default: ;  // Jumps, DoutR, Stall and unknown codes write nothing here
    endcase
  end

  // Jump decision, target is always the data word
  always_comb begin
    case (ins.opCode)
      JmpC:    ins.branchTaken = 1'b1;
      JeC:     ins.branchTaken = ins.valA[0];  // Equal flag
      JneC:    ins.branchTaken = !ins.valA[0];
      JzRC:    ins.branchTaken = (ins.valC == '0);
      JnzRC:   ins.branchTaken = (ins.valC != '0);
      default: ins.branchTaken = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

// ==== regFile.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "cpu_macros.svh"

module regFile import cpuPkg::*; (
  input wire   clk,
  input wire   rstN,
  regPortIf.rf rf
);

  word_t regs [`CPU_NUM_REGS];

  // Both writes land on the same edge
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < `CPU_NUM_REGS; i++) begin
        regs[i] <= '0;  // sp and flags start at 0 too
      end
    end else begin
      if (rf.resWe) begin
        regs[rf.resIdx] <= rf.resData;
      end
      // Later assignment, so sp update overrides a pop into r0
      if (rf.spWe) begin
        regs[`CPU_SP_REG] <= rf.spData;
      end
    end
  end

  // Combinational reads, no bypass needed
  always_comb begin
    for (int p = 0; p < 3; p++) begin
      rf.rdData[p] = regs[rf.rdIdx[p]];
    end
  end

  // Fixed-role registers seen directly by the sequencer
  assign rf.spValue   = regs[`CPU_SP_REG];
  assign rf.flagValue = regs[`CPU_FLAG_REG];

endmodule

`default_nettype wire

// ==== cpuIfs.sv ====
`default_nettype none
`timescale 1ns/100ps

// Decoded instruction plus what the operation unit makes of it
interface instrIf import cpuPkg::*; ();
  opCode_t opCode;
  regIdx_t regA;
  regIdx_t regB;
  regIdx_t regC;
  word_t   dataWord;     // Trailing word of long forms
  word_t   valA;         // Flags for JeC and JneC
  word_t   valB;         // Stack pointer for push and pop
  word_t   valC;
  word_t   result;
  logic    resultWe;
  logic    flagsWe;
  word_t   flags;
  addr_t   memAddr;
  word_t   storeData;
  word_t   spNext;
  logic    spWe;
  logic    branchTaken;

  modport seq (
    output opCode, regA, regB, regC, dataWord, valA, valB, valC,
    input  result, resultWe, flagsWe, flags, memAddr, storeData, spNext, spWe, branchTaken
  );
  modport exec (
    input  opCode, regA, regB, regC, dataWord, valA, valB, valC,
    output result, resultWe, flagsWe, flags, memAddr, storeData, spNext, spWe, branchTaken
  );
endinterface

// Register file access, three reads and two writes
interface regPortIf import cpuPkg::*; ();
  regIdx_t [2:0] rdIdx;   // A, B, C field order
  word_t   [2:0] rdData;
  word_t         spValue;
  word_t         flagValue;
  logic          resWe;
  regIdx_t       resIdx;
  word_t         resData;
  logic          spWe;    // Wins over resWe on register 0
  word_t         spData;

  modport seq (output rdIdx, resWe, resIdx, resData, spWe, spData,
               input  rdData, spValue, flagValue);
  modport rf (input  rdIdx, resWe, resIdx, resData, spWe, spData,
              output rdData, spValue, flagValue);
endinterface

`default_nettype wire

// ==== cpuPkg.sv ====
`default_nettype none

`include "cpu_macros.svh"

package cpuPkg;

  typedef logic [`CPU_DATA_W-1:0] word_t;      // One data word
  typedef logic [`CPU_REG_IDX_W-1:0] regIdx_t; // Register select
  typedef logic [`CPU_DATA_W-1:0] addr_t;      // Byte address

  // Byte 0 of every instruction
  typedef enum logic [7:0] {
    // Moves
    MovRC    = 8'h01,  // rA = const
    MovRR    = 8'h02,  // rA = rB
    MovRdC   = 8'h03,  // rA = [const]
    MovRdR   = 8'h04,  // rA = [rB]
    MovdCR   = 8'h05,  // [const] = rB
    MovdRoR  = 8'h06,  // [rA + const] = rB
    // Stack
    PushR    = 8'h10,
    PopR     = 8'h11,
    // Arithmetic, all wrap at 32 bits
    AddRRR   = 8'h20,
    AddRRC   = 8'h21,
    SubRRR   = 8'h22,
    SubRRC   = 8'h23,
    IncR     = 8'h24,
    DecR     = 8'h25,
    ShlRRR   = 8'h26,
    ShrRRR   = 8'h27,
    NegRR    = 8'h28,
    // Compares
    CmpRR    = 8'h30,  // Flags from rA vs rB
    CmpRC    = 8'h31,  // Flags from rA vs const
    CmpERRR  = 8'h32,  // rA = (rB == rC)
    CmpLtRRR = 8'h33,  // rA = (rB < rC)
    // Jumps, target in data word
    JmpC     = 8'h40,
    JeC      = 8'h41,
    JneC     = 8'h42,
    JzRC     = 8'h43,
    JnzRC    = 8'h44,
    // Other
    DoutR    = 8'h50,  // Debug output of rA
    Stall    = 8'h51   // Re-executes itself forever
  } opCode_t;

  // Sequencer steps, one cycle each
  typedef enum logic [3:0] {
    FetchIssue,  // Instruction read request
    FetchWait,
    Decode,      // Instruction word on ramIn
    RegRead,     // Operands out of the register file
    DataWait,    // Long forms only
    DataDone,
    MemIssue,    // Load, store, push, pop
    MemWait,
    MemDone,
    Commit       // Writeback and pointer update
  } seqState_t;

endpackage

`default_nettype wire

// ==== cpu_macros.svh ====
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// Datapath width, also used for byte addresses
`define CPU_DATA_W 32

// Flat register file, no windowing
`define CPU_NUM_REGS 16
`define CPU_REG_IDX_W 4  // Low nibble of each register byte

// Registers with a fixed role
`define CPU_SP_REG 0    // Stack pointer
`define CPU_FLAG_REG 1  // Compare flags

// Instruction sizes in bytes
`define CPU_INSTR_BYTES 4       // Opcode plus three register fields
`define CPU_LONG_INSTR_BYTES 8  // Short form plus trailing data word

// Stack grows upward, one word per push
`define CPU_STACK_STEP 4

`endif
